//--- Makefile
# Verilator build of the banked cache core testbench

VERILATOR ?= verilator
TOP       ?= tb_banked_cache_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv dv/*.sv dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up on a line of its own
run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/banked_cache_core.sv
`timescale 1ns/100ps

module banked_cache_core
    import cache_core_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    input  logic [NUM_REQS-1:0]       core_req_valid,
    input  logic [NUM_REQS-1:0]       core_req_rw,
    input  word_addr_t [NUM_REQS-1:0] core_req_addr,
    input  byteen_t [NUM_REQS-1:0]    core_req_byteen,
    input  word_t [NUM_REQS-1:0]      core_req_data,
    input  tag_t [NUM_REQS-1:0]       core_req_tag,
    output logic [NUM_REQS-1:0]       core_req_ready,

    output logic [NUM_REQS-1:0]       core_rsp_valid,
    output word_t [NUM_REQS-1:0]      core_rsp_data,
    output tag_t [NUM_REQS-1:0]       core_rsp_tag,
    input  logic [NUM_REQS-1:0]       core_rsp_ready,

    output perf_ctr_t                 req_stall_count
);

    logic [NUM_BANKS-1:0]       per_bank_req_valid;
    logic [NUM_BANKS-1:0]       per_bank_req_rw;
    line_addr_t [NUM_BANKS-1:0] per_bank_req_addr;
    wsel_t [NUM_BANKS-1:0]      per_bank_req_wsel;
    byteen_t [NUM_BANKS-1:0]    per_bank_req_byteen;
    word_t [NUM_BANKS-1:0]      per_bank_req_data;
    tag_t [NUM_BANKS-1:0]       per_bank_req_tag;
    tid_t [NUM_BANKS-1:0]       per_bank_req_tid;
    logic [NUM_BANKS-1:0]       per_bank_req_ready;

    logic [NUM_BANKS-1:0]       per_bank_rsp_valid;
    word_t [NUM_BANKS-1:0]      per_bank_rsp_data;
    tag_t [NUM_BANKS-1:0]       per_bank_rsp_tag;
    tid_t [NUM_BANKS-1:0]       per_bank_rsp_tid;
    logic [NUM_BANKS-1:0]       per_bank_rsp_ready;

    core_req_bank_sel u_bank_sel (
        .clk                 (clk),
        .reset               (reset),
        .core_req_valid      (core_req_valid),
        .core_req_rw         (core_req_rw),
        .core_req_addr       (core_req_addr),
        .core_req_byteen     (core_req_byteen),
        .core_req_data       (core_req_data),
        .core_req_tag        (core_req_tag),
        .core_req_ready      (core_req_ready),
        .per_bank_req_valid  (per_bank_req_valid),
        .per_bank_req_rw     (per_bank_req_rw),
        .per_bank_req_addr   (per_bank_req_addr),
        .per_bank_req_wsel   (per_bank_req_wsel),
        .per_bank_req_byteen (per_bank_req_byteen),
        .per_bank_req_data   (per_bank_req_data),
        .per_bank_req_tag    (per_bank_req_tag),
        .per_bank_req_tid    (per_bank_req_tid),
        .per_bank_req_ready  (per_bank_req_ready),
        .req_stall_count     (req_stall_count)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        cache_data_bank u_bank (
            .clk        (clk),
            .reset      (reset),
            .req_valid  (per_bank_req_valid[b]),
            .req_rw     (per_bank_req_rw[b]),
            .req_addr   (per_bank_req_addr[b]),
            .req_wsel   (per_bank_req_wsel[b]),
            .req_byteen (per_bank_req_byteen[b]),
            .req_data   (per_bank_req_data[b]),
            .req_tag    (per_bank_req_tag[b]),
            .req_tid    (per_bank_req_tid[b]),
            .req_ready  (per_bank_req_ready[b]),
            .rsp_valid  (per_bank_rsp_valid[b]),
            .rsp_data   (per_bank_rsp_data[b]),
            .rsp_tag    (per_bank_rsp_tag[b]),
            .rsp_tid    (per_bank_rsp_tid[b]),
            .rsp_ready  (per_bank_rsp_ready[b])
        );
    end

    core_rsp_merge u_rsp_merge (
        .per_bank_rsp_valid (per_bank_rsp_valid),
        .per_bank_rsp_data  (per_bank_rsp_data),
        .per_bank_rsp_tag   (per_bank_rsp_tag),
        .per_bank_rsp_tid   (per_bank_rsp_tid),
        .per_bank_rsp_ready (per_bank_rsp_ready),
        .core_rsp_valid     (core_rsp_valid),
        .core_rsp_data      (core_rsp_data),
        .core_rsp_tag       (core_rsp_tag),
        .core_rsp_ready     (core_rsp_ready)
    );

endmodule

//--- design/cache_core_pkg.sv
package cache_core_pkg;

    // Core lanes and banks
    localparam int NUM_REQS  = 4;
    localparam int NUM_BANKS = 4;

    // Word geometry
    localparam int WORD_SIZE      = 4;
    localparam int WORD_WIDTH     = WORD_SIZE * 8;
    localparam int WORDS_PER_LINE = 4;

    // Address split, word select in the low bits, then bank, then line index
    localparam int WORD_ADDR_WIDTH  = 12;
    localparam int WORD_SELECT_BITS = $clog2(WORDS_PER_LINE);
    localparam int BANK_SELECT_BITS = $clog2(NUM_BANKS);
    localparam int LINE_ADDR_WIDTH  = WORD_ADDR_WIDTH - WORD_SELECT_BITS;

    // Lines per bank follow from the line index width
    localparam int BANK_LINES = 2 ** (LINE_ADDR_WIDTH - BANK_SELECT_BITS);

    localparam int CORE_TAG_WIDTH = 3;
    localparam int REQS_BITS      = $clog2(NUM_REQS);

    localparam int PERF_CTR_WIDTH = 44;

    typedef logic [WORD_WIDTH-1:0]       word_t;
    typedef logic [WORD_ADDR_WIDTH-1:0]  word_addr_t;
    typedef logic [LINE_ADDR_WIDTH-1:0]  line_addr_t;
    typedef logic [WORD_SELECT_BITS-1:0] wsel_t;
    typedef logic [WORD_SIZE-1:0]        byteen_t;
    typedef logic [CORE_TAG_WIDTH-1:0]   tag_t;
    typedef logic [REQS_BITS-1:0]        tid_t;
    typedef logic [BANK_SELECT_BITS-1:0] bank_id_t;
    typedef logic [PERF_CTR_WIDTH-1:0]   perf_ctr_t;

endpackage

//--- design/cache_data_bank.sv
`timescale 1ns/100ps

module cache_data_bank
    import cache_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       req_valid,
    input  logic       req_rw,
    input  line_addr_t req_addr,
    input  wsel_t      req_wsel,
    input  byteen_t    req_byteen,
    input  word_t      req_data,
    input  tag_t       req_tag,
    input  tid_t       req_tid,
    output logic       req_ready,

    output logic       rsp_valid,
    output word_t      rsp_data,
    output tag_t       rsp_tag,
    output tid_t       rsp_tid,
    input  logic       rsp_ready
);

    localparam int BANK_WORDS = BANK_LINES * WORDS_PER_LINE;

    word_t mem [BANK_WORDS];

    logic [$clog2(BANK_WORDS)-1:0] word_idx;
    logic                          req_fire;
    logic                          rsp_fire;

    // Line index above the bank bits, then the word within the line
    assign word_idx = {req_addr[LINE_ADDR_WIDTH-1:BANK_SELECT_BITS], req_wsel};

    assign rsp_fire  = rsp_valid && rsp_ready;
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    // Byte-masked write
    always_ff @(posedge clk) begin
        if (req_fire && req_rw) begin
            for (int i = 0; i < WORD_SIZE; i++) begin
                if (req_byteen[i]) begin
                    mem[word_idx][i*8 +: 8] <= req_data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (req_fire && !req_rw) begin
            rsp_valid <= 1'b1;
        end else if (rsp_fire) begin
            rsp_valid <= 1'b0;
        end
    end

    // Response payload, loaded with the old word on a read
    always_ff @(posedge clk) begin
        if (req_fire && !req_rw) begin
            rsp_data <= mem[word_idx];
            rsp_tag  <= req_tag;
            rsp_tid  <= req_tid;
        end
    end

    // Held response must not move until the lane takes it
    a_rsp_hold: assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_tag)
    ) else $error("bank response changed under back-pressure");

endmodule

//--- design/core_req_bank_sel.sv
`timescale 1ns/100ps

module core_req_bank_sel
    import cache_core_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,

    input  logic [NUM_REQS-1:0]               core_req_valid,
    input  logic [NUM_REQS-1:0]               core_req_rw,
    input  word_addr_t [NUM_REQS-1:0]         core_req_addr,
    input  byteen_t [NUM_REQS-1:0]            core_req_byteen,
    input  word_t [NUM_REQS-1:0]              core_req_data,
    input  tag_t [NUM_REQS-1:0]               core_req_tag,
    output logic [NUM_REQS-1:0]               core_req_ready,

    output logic [NUM_BANKS-1:0]              per_bank_req_valid,
    output logic [NUM_BANKS-1:0]              per_bank_req_rw,
    output line_addr_t [NUM_BANKS-1:0]        per_bank_req_addr,
    output wsel_t [NUM_BANKS-1:0]             per_bank_req_wsel,
    output byteen_t [NUM_BANKS-1:0]           per_bank_req_byteen,
    output word_t [NUM_BANKS-1:0]             per_bank_req_data,
    output tag_t [NUM_BANKS-1:0]              per_bank_req_tag,
    output tid_t [NUM_BANKS-1:0]              per_bank_req_tid,
    input  logic [NUM_BANKS-1:0]              per_bank_req_ready,

    output perf_ctr_t                         req_stall_count
);

    line_addr_t [NUM_REQS-1:0] core_req_line_addr;
    wsel_t [NUM_REQS-1:0]      core_req_wsel;
    bank_id_t [NUM_REQS-1:0]   core_req_bid;

    // Ready lanes seen per bank, only read by the checks below
    logic [NUM_BANKS-1:0][NUM_REQS-1:0] bank_ready_lanes;

    // Address decode per lane
    for (genvar i = 0; i < NUM_REQS; i++) begin : g_decode
        assign core_req_line_addr[i] = core_req_addr[i][WORD_ADDR_WIDTH-1:WORD_SELECT_BITS];
        assign core_req_wsel[i]      = core_req_addr[i][WORD_SELECT_BITS-1:0];
        assign core_req_bid[i]       = core_req_addr[i][WORD_SELECT_BITS +: BANK_SELECT_BITS];
    end

    // Walk lanes from the top so the lowest valid lane of each bank is the last writer
    always_comb begin
        per_bank_req_valid  = '0;
        per_bank_req_rw     = '0;
        per_bank_req_addr   = '0;
        per_bank_req_wsel   = '0;
        per_bank_req_byteen = '0;
        per_bank_req_data   = '0;
        per_bank_req_tag    = '0;
        per_bank_req_tid    = '0;
        for (int i = NUM_REQS - 1; i >= 0; i--) begin
            if (core_req_valid[i]) begin
                per_bank_req_valid[core_req_bid[i]]  = 1'b1;
                per_bank_req_rw[core_req_bid[i]]     = core_req_rw[i];
                per_bank_req_addr[core_req_bid[i]]   = core_req_line_addr[i];
                per_bank_req_wsel[core_req_bid[i]]   = core_req_wsel[i];
                per_bank_req_byteen[core_req_bid[i]] = core_req_byteen[i];
                per_bank_req_data[core_req_bid[i]]   = core_req_data[i];
                per_bank_req_tag[core_req_bid[i]]    = core_req_tag[i];
                per_bank_req_tid[core_req_bid[i]]    = tid_t'(i);
            end
        end
    end

    // A lane is ready only if it owns its bank this cycle
    always_comb begin
        core_req_ready = '0;
        for (int i = 0; i < NUM_REQS; i++) begin
            core_req_ready[i] = core_req_valid[i]
                             && (per_bank_req_tid[core_req_bid[i]] == tid_t'(i))
                             && per_bank_req_ready[core_req_bid[i]];
        end
    end

    always_comb begin
        bank_ready_lanes = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < NUM_REQS; i++) begin
                bank_ready_lanes[b][i] = core_req_ready[i] && (core_req_bid[i] == bank_id_t'(b));
            end
        end
    end

    // Lane-cycles lost to bank conflicts or a full bank
    always_ff @(posedge clk) begin
        if (reset) begin
            req_stall_count <= '0;
        end else begin
            req_stall_count <= req_stall_count
                             + perf_ctr_t'($countones(core_req_valid & ~core_req_ready));
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_check
        // Bank ready must reach one lane at most
        a_one_lane_per_bank: assert property (
            @(posedge clk) disable iff (reset)
            $onehot0(bank_ready_lanes[b])
        ) else $error("bank %0d ready given to lanes %b", b, bank_ready_lanes[b]);
    end

endmodule

//--- design/core_rsp_merge.sv
`timescale 1ns/100ps

module core_rsp_merge
    import cache_core_pkg::*;
(
    input  logic [NUM_BANKS-1:0]  per_bank_rsp_valid,
    input  word_t [NUM_BANKS-1:0] per_bank_rsp_data,
    input  tag_t [NUM_BANKS-1:0]  per_bank_rsp_tag,
    input  tid_t [NUM_BANKS-1:0]  per_bank_rsp_tid,
    output logic [NUM_BANKS-1:0]  per_bank_rsp_ready,

    output logic [NUM_REQS-1:0]   core_rsp_valid,
    output word_t [NUM_REQS-1:0]  core_rsp_data,
    output tag_t [NUM_REQS-1:0]   core_rsp_tag,
    input  logic [NUM_REQS-1:0]   core_rsp_ready
);

    // One-hot bank grant per lane
    logic [NUM_REQS-1:0][NUM_BANKS-1:0] lane_grant;
    logic [NUM_BANKS-1:0][NUM_REQS-1:0] bank_lanes;

    // Scan banks downward so the lowest matching bank wins
    always_comb begin
        lane_grant = '0;
        for (int i = 0; i < NUM_REQS; i++) begin
            for (int j = NUM_BANKS - 1; j >= 0; j--) begin
                if (per_bank_rsp_valid[j] && (per_bank_rsp_tid[j] == tid_t'(i))) begin
                    lane_grant[i]    = '0;
                    lane_grant[i][j] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        core_rsp_valid     = '0;
        core_rsp_data      = '0;
        core_rsp_tag       = '0;
        per_bank_rsp_ready = '0;
        for (int i = 0; i < NUM_REQS; i++) begin
            for (int j = 0; j < NUM_BANKS; j++) begin
                if (lane_grant[i][j]) begin
                    core_rsp_valid[i]     = 1'b1;
                    core_rsp_data[i]      = per_bank_rsp_data[j];
                    core_rsp_tag[i]       = per_bank_rsp_tag[j];
                    per_bank_rsp_ready[j] = core_rsp_ready[i];
                end
            end
        end
    end

    // No clock here, so the grant check is done on settled combinational values
    always_comb begin
        bank_lanes = '0;
        for (int j = 0; j < NUM_BANKS; j++) begin
            for (int i = 0; i < NUM_REQS; i++) begin
                bank_lanes[j][i] = lane_grant[i][j];
            end
            a_bank_one_lane: assert final ($onehot0(bank_lanes[j]))
                else $error("bank %0d granted to lanes %b", j, bank_lanes[j]);
        end
    end

endmodule

//--- dv/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Wrong values and other failures are counted apart
int value_errors = 0;
int other_errors = 0;

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

task automatic check_ready(input string name, input logic [NUM_REQS-1:0] got,
                           input logic [NUM_REQS-1:0] exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
endtask

task automatic check_count(input string name, input perf_ctr_t got, input perf_ctr_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

// Anything that is not a simple value mismatch
task automatic report_failure(input string what);
    other_errors++;
    $display("ERROR at %0t ns: %s", $time, what);
endtask

`endif

//--- dv/tb_banked_cache_core.sv
`timescale 1ns/100ps

module tb_banked_cache_core
    import cache_core_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int SAMPLE_DELAY  = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int ADDR_SPAN     = 32;
    localparam int RAND_PER_LANE = 400;
    localparam int DIRECTED_OPS  = 6;
    localparam int DRAIN_CYCLES  = 200;
    localparam int NUM_TAGS      = 2 ** CORE_TAG_WIDTH;
    localparam int TOTAL_REQS    = ADDR_SPAN + NUM_REQS * (DIRECTED_OPS + RAND_PER_LANE);
    localparam word_addr_t ADDR_BASE = 12'h5a0;

    typedef enum logic [1:0] {QUEUED, RANDOM, DRAIN} phase_t;

    typedef struct packed {
        logic       rw;
        word_addr_t addr;
        byteen_t    byteen;
        word_t      data;
    } op_t;

    typedef struct packed {
        tag_t  tag;
        word_t data;
    } read_t;

    logic                      clk;
    logic                      reset;
    logic [NUM_REQS-1:0]       core_req_valid;
    logic [NUM_REQS-1:0]       core_req_rw;
    word_addr_t [NUM_REQS-1:0] core_req_addr;
    byteen_t [NUM_REQS-1:0]    core_req_byteen;
    word_t [NUM_REQS-1:0]      core_req_data;
    tag_t [NUM_REQS-1:0]       core_req_tag;
    logic [NUM_REQS-1:0]       core_req_ready;
    logic [NUM_REQS-1:0]       core_rsp_valid;
    word_t [NUM_REQS-1:0]      core_rsp_data;
    tag_t [NUM_REQS-1:0]       core_rsp_tag;
    logic [NUM_REQS-1:0]       core_rsp_ready;
    perf_ctr_t                 req_stall_count;

    // Reference memory and per-lane bookkeeping
    word_t                              ref_mem [2 ** WORD_ADDR_WIDTH];
    op_t                                op_q [NUM_REQS][$];
    read_t                              pending [NUM_REQS][$];
    logic [NUM_REQS-1:0][NUM_TAGS-1:0]  tag_busy;
    int                                 rand_issued [NUM_REQS];
    logic [NUM_REQS-1:0]                accepted;
    logic [NUM_REQS-1:0]                watch_hold;
    word_t [NUM_REQS-1:0]               held_data;
    tag_t [NUM_REQS-1:0]                held_tag;
    perf_ctr_t                          stall_sum;
    phase_t                             phase;
    logic                               first_after_reset;

    `include "tb_checks.svh"

    banked_cache_core DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (TOTAL_REQS * 20) @(posedge clk);
        report_failure($sformatf("watchdog expired after %0d cycles", TOTAL_REQS * 20));
        $display("TEST FAIL");
        $finish;
    end

    function automatic bank_id_t bank_of(input word_addr_t a);
        return a[WORD_SELECT_BITS +: BANK_SELECT_BITS];
    endfunction

    function automatic word_t fill_word(input word_addr_t a);
        return {4'ha, a, 4'h5, ~a};
    endfunction

    function automatic op_t make_op(input logic rw, input word_addr_t addr,
                                    input byteen_t byteen, input word_t data);
        op_t op;
        op.rw     = rw;
        op.addr   = addr;
        op.byteen = byteen;
        op.data   = data;
        return op;
    endfunction

    function automatic op_t random_op();
        op_t op;
        op.rw     = ($urandom % 2) == 0;
        op.addr   = ADDR_BASE + word_addr_t'($urandom % ADDR_SPAN);
        op.byteen = byteen_t'($urandom);
        op.data   = $urandom;
        return op;
    endfunction

    // Reads need a tag that is not in flight on this lane
    function automatic bit issue_op(input int lane, input op_t op);
        int start;
        int t;
        t = -1;
        if (op.rw) begin
            t = 0;
        end else begin
            start = $urandom % NUM_TAGS;
            for (int k = 0; k < NUM_TAGS; k++) begin
                if (t < 0 && !tag_busy[lane][(start + k) % NUM_TAGS]) begin
                    t = (start + k) % NUM_TAGS;
                end
            end
            if (t < 0) begin
                return 1'b0;
            end
            tag_busy[lane][t] = 1'b1;
        end
        core_req_valid[lane]  = 1'b1;
        core_req_rw[lane]     = op.rw;
        core_req_addr[lane]   = op.addr;
        core_req_byteen[lane] = op.byteen;
        core_req_data[lane]   = op.data;
        core_req_tag[lane]    = tag_t'(t);
        return 1'b1;
    endfunction

    task automatic apply_request(input int lane);
        read_t rd;
        if (core_req_rw[lane]) begin
            for (int b = 0; b < WORD_SIZE; b++) begin
                if (core_req_byteen[lane][b]) begin
                    ref_mem[core_req_addr[lane]][b*8 +: 8] = core_req_data[lane][b*8 +: 8];
                end
            end
        end else begin
            rd.tag  = core_req_tag[lane];
            rd.data = ref_mem[core_req_addr[lane]];
            pending[lane].push_back(rd);
        end
    endtask

    task automatic retire_read(input int lane);
        int idx;
        idx = -1;
        for (int k = 0; k < pending[lane].size(); k++) begin
            if (idx < 0 && pending[lane][k].tag == core_rsp_tag[lane]) begin
                idx = k;
            end
        end
        if (idx < 0) begin
            report_failure($sformatf("lane %0d returned tag %0d with no read outstanding",
                                     lane, core_rsp_tag[lane]));
        end else begin
            check_word($sformatf("core_rsp_data[%0d]", lane), core_rsp_data[lane],
                       pending[lane][idx].data);
            pending[lane].delete(idx);
            tag_busy[lane][core_rsp_tag[lane]] = 1'b0;
        end
    endtask

    // One clock cycle, drive on the falling edge and sample shortly before the rising one
    task automatic step();
        logic [NUM_REQS-1:0] allowed;
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_REQS; i++) begin
            if (accepted[i]) begin
                core_req_valid[i] = 1'b0;
            end
            if (!core_req_valid[i] && phase == QUEUED && op_q[i].size() > 0) begin
                if (issue_op(i, op_q[i][0])) begin
                    void'(op_q[i].pop_front());
                end
            end else if (!core_req_valid[i] && phase == RANDOM
                         && rand_issued[i] < RAND_PER_LANE && $urandom % 4 != 0) begin
                if (issue_op(i, random_op())) begin
                    rand_issued[i]++;
                end
            end
            core_rsp_ready[i] = (phase != RANDOM) || ($urandom % 4 != 0);
        end

        #(SAMPLE_DELAY);
        if (first_after_reset) begin
            check_ready("core_rsp_valid", core_rsp_valid, '0);
        end
        first_after_reset = 1'b0;
        check_count("req_stall_count", req_stall_count, stall_sum);
        stall_sum += perf_ctr_t'($countones(core_req_valid & ~core_req_ready));

        // Only the lowest valid lane of a bank may see ready
        for (int i = 0; i < NUM_REQS; i++) begin
            allowed[i] = core_req_valid[i];
            for (int h = 0; h < i; h++) begin
                if (core_req_valid[h] && bank_of(core_req_addr[h]) == bank_of(core_req_addr[i])) begin
                    allowed[i] = 1'b0;
                end
            end
        end
        check_ready("core_req_ready outside lowest lane per bank", core_req_ready & ~allowed, '0);
        accepted = core_req_valid & core_req_ready;

        for (int i = 0; i < NUM_REQS; i++) begin
            if (watch_hold[i]) begin
                if (!core_rsp_valid[i]) begin
                    report_failure($sformatf("lane %0d dropped a response while not ready", i));
                end
                check_word($sformatf("core_rsp_data[%0d]", i), core_rsp_data[i], held_data[i]);
                check_tag($sformatf("core_rsp_tag[%0d]", i), core_rsp_tag[i], held_tag[i]);
            end
            if (core_rsp_valid[i] && core_rsp_ready[i]) begin
                retire_read(i);
            end
            if (accepted[i]) begin
                apply_request(i);
            end
            // A read just accepted into a lower bank may take the lane over
            watch_hold[i] = core_rsp_valid[i] && !core_rsp_ready[i]
                         && !(accepted[i] && !core_req_rw[i]);
            held_data[i]  = core_rsp_data[i];
            held_tag[i]   = core_rsp_tag[i];
        end
    endtask

    function automatic bit queued_left();
        bit left;
        left = |(core_req_valid & ~accepted);
        for (int i = 0; i < NUM_REQS; i++) begin
            left |= op_q[i].size() > 0;
        end
        return left;
    endfunction

    function automatic bit random_left();
        bit left;
        left = 1'b0;
        for (int i = 0; i < NUM_REQS; i++) begin
            left |= rand_issued[i] < RAND_PER_LANE;
        end
        return left;
    endfunction

    function automatic bit reads_left();
        bit left;
        left = |(core_req_valid & ~accepted);
        for (int i = 0; i < NUM_REQS; i++) begin
            left |= pending[i].size() > 0;
        end
        return left;
    endfunction

    initial begin
        void'($urandom(32'h887f_8e59));
        reset             = 1'b1;
        core_req_valid    = '0;
        core_req_rw       = '0;
        core_req_addr     = '0;
        core_req_byteen   = '0;
        core_req_data     = '0;
        core_req_tag      = '0;
        core_rsp_ready    = '0;
        accepted          = '0;
        watch_hold        = '0;
        held_data         = '0;
        held_tag          = '0;
        tag_busy          = '0;
        stall_sum         = '0;
        phase             = QUEUED;
        first_after_reset = 1'b1;
        for (int i = 0; i < NUM_REQS; i++) begin
            rand_issued[i] = 0;
        end

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #(SAMPLE_DELAY);
            check_ready("core_rsp_valid", core_rsp_valid, '0);
        end

        // Full-word fill of the whole address window
        for (int k = 0; k < ADDR_SPAN; k++) begin
            op_q[k % NUM_REQS].push_back(make_op(1'b1, ADDR_BASE + word_addr_t'(k), 4'hf,
                                                 fill_word(ADDR_BASE + word_addr_t'(k))));
        end
        while (queued_left()) step();

        // Partial writes merged into one word per bank, read back in between
        for (int i = 0; i < NUM_REQS; i++) begin
            op_q[i].push_back(make_op(1'b1, ADDR_BASE + word_addr_t'(4 * i), 4'b0001, $urandom));
            op_q[i].push_back(make_op(1'b1, ADDR_BASE + word_addr_t'(4 * i), 4'b0100, $urandom));
            op_q[i].push_back(make_op(1'b0, ADDR_BASE + word_addr_t'(4 * i), 4'b0000, '0));
            op_q[i].push_back(make_op(1'b1, ADDR_BASE + word_addr_t'(4 * i), 4'b1010, $urandom));
            op_q[i].push_back(make_op(1'b1, ADDR_BASE + word_addr_t'(4 * i), 4'b0110, $urandom));
            op_q[i].push_back(make_op(1'b0, ADDR_BASE + word_addr_t'(4 * i), 4'b0000, '0));
        end
        while (queued_left()) step();

        phase = RANDOM;
        while (random_left()) step();

        phase = DRAIN;
        for (int n = 0; n < DRAIN_CYCLES && reads_left(); n++) begin
            step();
        end
        for (int i = 0; i < NUM_REQS; i++) begin
            if (pending[i].size() != 0 || core_req_valid[i] && !accepted[i]) begin
                report_failure($sformatf("lane %0d still has %0d reads outstanding at the end",
                                         i, pending[i].size()));
            end
        end

        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+dv
design/cache_core_pkg.sv
design/core_req_bank_sel.sv
design/cache_data_bank.sv
design/core_rsp_merge.sv
design/banked_cache_core.sv
dv/tb_banked_cache_core.sv
